// File: Makefile
# Verilator build, run and lint for the RV32M multiply accelerator

VERILATOR ?= verilator
TOP       ?= tb_mul_top
RTL_TOP   ?= mul_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Testbench passed

SOURCES  := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hw/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/approx_multiplier.sv
`timescale 1ns/1ps
/*
  Iterative shift-add multiplier
  Signed 33x33 operands in, 64-bit two's-complement product out
  With accuracy control built in, low operand bits are cleared first
*/
module approx_multiplier #(
  parameter int acc_ctrl = 0
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic signed [mul_pkg::xlen:0]  opa,
  input  logic signed [mul_pkg::xlen:0]  opb,
  input  logic [mul_pkg::acc_w-1:0]      accuracy,
  output logic                           busy,
  output logic                           done,
  output logic [2*mul_pkg::xlen-1:0]     product
);
  import mul_pkg::*;

  localparam int cnt_w = $clog2(mul_latency + 1);

  logic [4:0]           trunc_n;     // Low bits to drop, clamped to 31
  logic [xlen:0]        trunc_mask;
  logic signed [xlen:0] ta;          // Truncated operands
  logic signed [xlen:0] tb;
  logic [xlen:0]        ma;          // Magnitudes at load
  logic [xlen:0]        mb;
  logic [xlen:0]        mcand;       // Held multiplicand magnitude
  logic [xlen:0]        acc_hi;      // Upper half of running sum
  logic [xlen:0]        mq;          // Multiplier, consumed LSB first
  logic                 neg;         // Result sign
  logic [cnt_w-1:0]     cnt;         // Iterations left
  logic [xlen+1:0]      sum;         // One add with carry
  logic [2*xlen+1:0]    mag_next;    // Shifted {sum, mq}

  always_comb begin
    if (acc_ctrl == 0 || accuracy == '0) begin
      trunc_n = '0;                  // Exact multiply
    end else if (accuracy > acc_w'(31)) begin
      trunc_n = 5'd31;
    end else begin
      trunc_n = accuracy[4:0];
    end
  end

  assign trunc_mask = {(xlen+1){1'b1}} << trunc_n;
  assign ta = opa & trunc_mask;
  assign tb = opb & trunc_mask;
  assign ma = ta[xlen] ? -ta : ta;   // Cannot overflow for 32-bit sources
  assign mb = tb[xlen] ? -tb : tb;

  // Add multiplicand when the current multiplier bit is set, then shift right
  assign sum      = {1'b0, acc_hi} + (mq[0] ? {1'b0, mcand} : '0);
  assign mag_next = {sum, mq[xlen:1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      cnt     <= '0;
      mcand   <= '0;
      acc_hi  <= '0;
      mq      <= '0;
      neg     <= 1'b0;
      product <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // Load cycle
        mcand  <= ma;
        mq     <= mb;
        acc_hi <= '0;
        neg    <= ta[xlen] ^ tb[xlen];
        cnt    <= cnt_w'(mul_latency);
        busy   <= 1'b1;
      end else if (busy) begin
        acc_hi <= mag_next[2*xlen+1:xlen+1];
        mq     <= mag_next[xlen:0];
        cnt    <= cnt - 1'b1;
        if (cnt == cnt_w'(1)) begin
          // Last step lands the signed product together with done
          busy    <= 1'b0;
          done    <= 1'b1;
          product <= neg ? -mag_next[2*xlen-1:0] : mag_next[2*xlen-1:0];
        end
      end
    end
  end

  // The unit above must hold off a new start until this run finishes
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done);

endmodule

// File: hw/mul_axil_regs.sv
`timescale 1ns/1ps
/*
  AXI4-Lite register file for the multiply accelerator
  Holds instruction, operands and accuracy, issues the start pulse
  and captures the result with a sticky done flag
*/
module mul_axil_regs (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [mul_pkg::axil_addr_w-1:0]   s_axil_awaddr,
  input  logic                              s_axil_awvalid,
  output logic                              s_axil_awready,
  input  logic [mul_pkg::xlen-1:0]          s_axil_wdata,
  input  logic [mul_pkg::xlen/8-1:0]        s_axil_wstrb,
  input  logic                              s_axil_wvalid,
  output logic                              s_axil_wready,
  output logic [1:0]                        s_axil_bresp,
  output logic                              s_axil_bvalid,
  input  logic                              s_axil_bready,
  input  logic [mul_pkg::axil_addr_w-1:0]   s_axil_araddr,
  input  logic                              s_axil_arvalid,
  output logic                              s_axil_arready,
  output logic [mul_pkg::xlen-1:0]          s_axil_rdata,
  output logic [1:0]                        s_axil_rresp,
  output logic                              s_axil_rvalid,
  input  logic                              s_axil_rready,
  output logic                              start,
  output mul_pkg::instr_u                   instr,
  output logic [mul_pkg::xlen-1:0]          rs1,
  output logic [mul_pkg::xlen-1:0]          rs2,
  output logic [mul_pkg::acc_w-1:0]         accuracy_level,
  input  logic                              busy,
  input  logic                              done,
  input  logic                              illegal,
  input  logic [mul_pkg::xlen-1:0]          result
);
  import mul_pkg::*;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic            wr_en;        // Write address and data accepted
  logic            rd_en;        // Read address accepted
  logic            wr_mapped;
  logic            rd_mapped;
  logic            start_req;    // Host asked for a start
  logic            launch;       // Start actually issued
  logic            done_sticky;
  logic [xlen-1:0] result_q;
  logic [xlen-1:0] rd_word;

  // Byte lane merge for strobed writes
  function automatic logic [xlen-1:0] merge_bytes(input logic [xlen-1:0]   old_v,
                                                  input logic [xlen-1:0]   new_v,
                                                  input logic [xlen/8-1:0] strb);
    logic [xlen-1:0] v;
    v = old_v;
    for (int i = 0; i < xlen / 8; i++) begin
      if (strb[i]) v[8*i +: 8] = new_v[8*i +: 8];
    end
    return v;
  endfunction

  // A pending response stalls its own channel
  assign wr_en          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign s_axil_awready = wr_en;
  assign s_axil_wready  = wr_en;
  assign rd_en          = s_axil_arvalid && !s_axil_rvalid;
  assign s_axil_arready = rd_en;

  always_comb begin
    case (s_axil_awaddr)
      reg_ctrl, reg_instr, reg_rs1, reg_rs2, reg_acc, reg_result: wr_mapped = 1'b1;
      default: wr_mapped = 1'b0;
    endcase
  end

  assign start_req = wr_en && (s_axil_awaddr == reg_ctrl) &&
                     s_axil_wstrb[0] && s_axil_wdata[0];
  assign launch    = start_req && !(busy || start);  // Dropped while a run is active

  always_ff @(posedge clk) begin
    if (rst) begin
      s_axil_bvalid  <= 1'b0;
      s_axil_bresp   <= resp_okay;
      start          <= 1'b0;
      instr          <= '0;
      rs1            <= '0;
      rs2            <= '0;
      accuracy_level <= '0;
      done_sticky    <= 1'b0;
      result_q       <= '0;
    end else begin
      start <= launch;
      if (wr_en) begin
        s_axil_bvalid <= 1'b1;
        s_axil_bresp  <= wr_mapped ? resp_okay : resp_slverr;
        case (s_axil_awaddr)
          reg_instr: instr.raw <= merge_bytes(instr.raw, s_axil_wdata, s_axil_wstrb);
          reg_rs1:   rs1 <= merge_bytes(rs1, s_axil_wdata, s_axil_wstrb);
          reg_rs2:   rs2 <= merge_bytes(rs2, s_axil_wdata, s_axil_wstrb);
          reg_acc: begin
            if (s_axil_wstrb[0]) accuracy_level <= s_axil_wdata[acc_w-1:0];
          end
          default: ;  // ctrl goes through launch and result is read only
        endcase
      end else if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (launch) begin
        done_sticky <= 1'b0;
      end else if (done) begin
        done_sticky <= 1'b1;
      end
      if (done) result_q <= result;
    end
  end

  always_comb begin
    rd_mapped = 1'b1;
    case (s_axil_araddr)
      reg_ctrl:   rd_word = {{(xlen-3){1'b0}}, illegal, done_sticky, busy || start};
      reg_instr:  rd_word = instr.raw;
      reg_rs1:    rd_word = rs1;
      reg_rs2:    rd_word = rs2;
      reg_acc:    rd_word = {{(xlen-acc_w){1'b0}}, accuracy_level};
      reg_result: rd_word = result_q;
      default: begin
        rd_word   = '0;
        rd_mapped = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s_axil_rvalid <= 1'b0;
      s_axil_rresp  <= resp_okay;
      s_axil_rdata  <= '0;
    end else if (rd_en) begin
      s_axil_rvalid <= 1'b1;
      s_axil_rdata  <= rd_word;
      s_axil_rresp  <= rd_mapped ? resp_okay : resp_slverr;
    end else if (s_axil_rvalid && s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid);

endmodule

// File: hw/mul_operand_decode.sv
`timescale 1ns/1ps
/*
  Multiply operand decode
  Checks an R-type word for a legal MUL group op and
  extends both source operands to 33 bits for the signed core
*/
module mul_operand_decode (
  input  mul_pkg::instr_u              instr,
  input  logic [mul_pkg::xlen-1:0]     rs1,
  input  logic [mul_pkg::xlen-1:0]     rs2,
  output logic                         legal,
  output mul_pkg::mul_op_e             op,
  output logic signed [mul_pkg::xlen:0] opa,
  output logic signed [mul_pkg::xlen:0] opb
);
  import mul_pkg::*;

  logic a_signed;  // rs1 treated as signed
  logic b_signed;  // rs2 treated as signed

  // Only OP with funct7 0000001 and funct3 below 4 is a multiply
  always_comb begin
    legal = (instr.rtype.opcode == opcode_op) &&
            (instr.rtype.funct7 == funct7_muldiv) &&
            !instr.rtype.funct3[2];
  end

  always_comb begin
    case (instr.rtype.funct3)
      funct3_mul:    op = op_mul;
      funct3_mulh:   op = op_mulh;
      funct3_mulhsu: op = op_mulhsu;
      funct3_mulhu:  op = op_mulhu;
      default:       op = op_mul;  // Divide group, flagged by legal
    endcase
  end

  assign a_signed = (op != op_mulhu);
  assign b_signed = (op == op_mul) || (op == op_mulh);

  // MSB extension picks signed or unsigned reading of each source
  assign opa = {a_signed & rs1[xlen-1], rs1};
  assign opb = {b_signed & rs2[xlen-1], rs2};

endmodule

// File: hw/mul_pkg.sv
/*
  Shared definitions for the RV32M multiply accelerator
  Instruction encodings, instruction word views, register map and widths
*/
package mul_pkg;

  localparam int xlen        = 32;  // Operand width
  localparam int acc_w       = 8;   // Accuracy level width
  localparam int axil_addr_w = 8;   // AXI4-Lite byte address width
  localparam int mul_latency = 33;  // Shift-add iterations per multiply

  // R-type encodings of the M extension multiply group
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;
  localparam logic [2:0] funct3_mul    = 3'd0;
  localparam logic [2:0] funct3_mulh   = 3'd1;
  localparam logic [2:0] funct3_mulhsu = 3'd2;
  localparam logic [2:0] funct3_mulhu  = 3'd3;

  // R-type field layout, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // Same 32-bit word seen raw by the bus and as fields by the decoder
  typedef union packed {
    logic [31:0] raw;
    rtype_t      rtype;
  } instr_u;

  typedef enum logic [1:0] {
    op_mul,
    op_mulh,
    op_mulhsu,
    op_mulhu
  } mul_op_e;

  // Register map, byte offsets
  localparam logic [axil_addr_w-1:0] reg_ctrl   = 8'h00;
  localparam logic [axil_addr_w-1:0] reg_instr  = 8'h04;
  localparam logic [axil_addr_w-1:0] reg_rs1    = 8'h08;
  localparam logic [axil_addr_w-1:0] reg_rs2    = 8'h0C;
  localparam logic [axil_addr_w-1:0] reg_acc    = 8'h10;
  localparam logic [axil_addr_w-1:0] reg_result = 8'h14;

endpackage

// File: hw/mul_top.sv
`timescale 1ns/1ps
/*
  Multiply accelerator top level
  AXI4-Lite register file in front of the RV32M multiply unit
*/
module mul_top #(
  parameter int acc_ctrl = 1
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [mul_pkg::axil_addr_w-1:0]   s_axil_awaddr,
  input  logic                              s_axil_awvalid,
  output logic                              s_axil_awready,
  input  logic [mul_pkg::xlen-1:0]          s_axil_wdata,
  input  logic [mul_pkg::xlen/8-1:0]        s_axil_wstrb,
  input  logic                              s_axil_wvalid,
  output logic                              s_axil_wready,
  output logic [1:0]                        s_axil_bresp,
  output logic                              s_axil_bvalid,
  input  logic                              s_axil_bready,
  input  logic [mul_pkg::axil_addr_w-1:0]   s_axil_araddr,
  input  logic                              s_axil_arvalid,
  output logic                              s_axil_arready,
  output logic [mul_pkg::xlen-1:0]          s_axil_rdata,
  output logic [1:0]                        s_axil_rresp,
  output logic                              s_axil_rvalid,
  input  logic                              s_axil_rready
);
  import mul_pkg::*;

  logic             start;           // One-cycle launch
  instr_u           instr;
  logic [xlen-1:0]  rs1;
  logic [xlen-1:0]  rs2;
  logic [acc_w-1:0] accuracy_level;
  logic             busy;
  logic             done;            // One-cycle completion
  logic             illegal;
  logic [xlen-1:0]  result;

  mul_axil_regs u_regs (
    .clk            (clk),
    .rst            (rst),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .start          (start),
    .instr          (instr),
    .rs1            (rs1),
    .rs2            (rs2),
    .accuracy_level (accuracy_level),
    .busy           (busy),
    .done           (done),
    .illegal        (illegal),
    .result         (result)
  );

  mul_unit #(
    .acc_ctrl (acc_ctrl)
  ) u_mul_unit (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .instr          (instr),
    .rs1            (rs1),
    .rs2            (rs2),
    .accuracy_level (accuracy_level),
    .busy           (busy),
    .done           (done),
    .illegal        (illegal),
    .result         (result)
  );

endmodule

// File: hw/mul_unit.sv
`timescale 1ns/1ps
/*
  RV32M multiply unit
  Decodes MUL, MULH, MULHSU and MULHU, runs the iterative core
  and returns the selected product half, or flags an illegal word
*/
module mul_unit #(
  parameter int acc_ctrl = 1
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  mul_pkg::instr_u            instr,
  input  logic [mul_pkg::xlen-1:0]   rs1,
  input  logic [mul_pkg::xlen-1:0]   rs2,
  input  logic [mul_pkg::acc_w-1:0]  accuracy_level,
  output logic                       busy,
  output logic                       done,
  output logic                       illegal,
  output logic [mul_pkg::xlen-1:0]   result
);
  import mul_pkg::*;

  logic                 dec_legal;
  mul_op_e              dec_op;
  logic signed [xlen:0] opa;
  logic signed [xlen:0] opb;
  mul_op_e              op_q;        // Op of the multiply in flight
  logic                 ill_done;    // Early completion for a bad word
  logic                 core_start;
  logic                 core_busy;
  logic                 core_done;
  logic [2*xlen-1:0]    product;

  mul_operand_decode u_decode (
    .instr (instr),
    .rs1   (rs1),
    .rs2   (rs2),
    .legal (dec_legal),
    .op    (dec_op),
    .opa   (opa),
    .opb   (opb)
  );

  assign core_start = start && dec_legal;  // Illegal words never reach the core

  approx_multiplier #(
    .acc_ctrl (acc_ctrl)
  ) u_core (
    .clk      (clk),
    .rst      (rst),
    .start    (core_start),
    .opa      (opa),
    .opb      (opb),
    .accuracy (accuracy_level),
    .busy     (core_busy),
    .done     (core_done),
    .product  (product)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q     <= op_mul;
      illegal  <= 1'b0;
      ill_done <= 1'b0;
    end else begin
      ill_done <= start && !dec_legal;
      if (start) begin
        op_q    <= dec_op;
        illegal <= !dec_legal;  // Held until the next start
      end
    end
  end

  assign busy = core_busy;
  assign done = core_done | ill_done;

  // Product is a core register written on the done edge,
  // so the half select is valid in the same cycle as done
  always_comb begin
    if (illegal) begin
      result = '0;
    end else if (op_q == op_mul) begin
      result = product[xlen-1:0];
    end else begin
      result = product[2*xlen-1:xlen];   // MULH, MULHSU, MULHU
    end
  end

  // Register file must not launch in the completion cycle
  a_no_start_on_done: assert property (@(posedge clk) disable iff (rst)
    !(done && start));

endmodule

// File: list.f
hw/mul_pkg.sv
hw/mul_operand_decode.sv
hw/approx_multiplier.sv
hw/mul_unit.sv
hw/mul_axil_regs.sv
hw/mul_top.sv
test/tb_mul_top.sv

// File: test/tb_mul_top.sv
`timescale 1ns/1ps
/*
  Testbench for the multiply accelerator top level
  Runs RV32M multiplies over AXI4-Lite and checks them against a reference model
*/
module tb_mul_top;
  import mul_pkg::*;

  localparam int         bus_timeout = 50;     // Cycles allowed per handshake
  localparam int         poll_limit  = 100;    // ctrl reads before giving up on done
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic        clk;
  logic        rst;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  logic [31:0] exp_q[$];   // Expected results from the tests
  logic [31:0] got_q[$];   // Result register reads
  logic [31:0] cmp_exp;
  logic [31:0] cmp_got;

  mul_top #(
    .acc_ctrl (1)
  ) u_mul_top (
    .clk            (clk),
    .rst            (rst),
    .s_axil_awaddr  (awaddr),
    .s_axil_awvalid (awvalid),
    .s_axil_awready (awready),
    .s_axil_wdata   (wdata),
    .s_axil_wstrb   (wstrb),
    .s_axil_wvalid  (wvalid),
    .s_axil_wready  (wready),
    .s_axil_bresp   (bresp),
    .s_axil_bvalid  (bvalid),
    .s_axil_bready  (bready),
    .s_axil_araddr  (araddr),
    .s_axil_arvalid (arvalid),
    .s_axil_arready (arready),
    .s_axil_rdata   (rdata),
    .s_axil_rresp   (rresp),
    .s_axil_rvalid  (rvalid),
    .s_axil_rready  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // R-type word with fixed register numbers
  function automatic logic [31:0] make_instr(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  // Expected result from the RV32M rules and the truncation rule
  function automatic logic [31:0] ref_mul(input logic [31:0] ins, input logic [31:0] a,
                                          input logic [31:0] b, input logic [7:0] acc);
    logic [2:0]         f3;
    logic [4:0]         n;
    logic [32:0]        mask;
    logic signed [32:0] xa;
    logic signed [32:0] xb;
    longint             sa;
    longint             sb;
    longint             p;
    f3 = ins[14:12];
    if (ins[6:0] != 7'b0110011 || ins[31:25] != 7'b0000001 || f3[2]) begin
      return 32'h0;                          // Not a multiply
    end
    xa = {(f3 != 3'd3) & a[31], a};          // MULHU reads rs1 unsigned
    xb = {(f3 <= 3'd1) & b[31], b};          // Only MUL and MULH read rs2 signed
    n = (acc > 8'd31) ? 5'd31 : acc[4:0];    // Clamp to 31 dropped bits
    mask = {33{1'b1}} << n;
    xa = xa & mask;
    xb = xb & mask;
    sa = longint'(xa);
    sb = longint'(xb);
    p = sa * sb;                             // Low 64 bits are the full product
    return (f3 == 3'd0) ? p[31:0] : p[63:32];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got == exp) else begin
      $display("Fail %s exp=%h got=%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    errors++;
  endtask

  // Write with bready held low for hold cycles once bvalid is up
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold, output logic [1:0] resp);
    int n;
    resp = 2'b11;
    n = 0;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge clk);
    while (!(awready && wready) && n < bus_timeout) begin
      @(negedge clk);
      n++;
    end
    if (!(awready && wready)) begin
      report_problem("Timeout waiting for the write to be accepted");
      awvalid = 1'b0;
      wvalid = 1'b0;
      return;
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!bvalid && n < bus_timeout) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid) begin
      report_problem("Timeout waiting for the write response");
      return;
    end
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!bvalid) report_problem("Write response dropped before bready");
    end
    @(posedge clk);
    #1 bready = 1'b1;
    @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1 bready = 1'b0;
  endtask

  // Read with rready held low for hold cycles once rvalid is up
  task automatic axil_read(input logic [7:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int n;
    data = 32'h0;
    resp = 2'b11;
    n = 0;
    araddr = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready && n < bus_timeout) begin
      @(negedge clk);
      n++;
    end
    if (!arready) begin
      report_problem("Timeout waiting for the read address to be accepted");
      arvalid = 1'b0;
      return;
    end
    @(posedge clk);
    #1 arvalid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!rvalid && n < bus_timeout) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) begin
      report_problem("Timeout waiting for read data");
      return;
    end
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!rvalid) report_problem("Read data dropped before rready");
    end
    @(posedge clk);
    #1 rready = 1'b1;
    @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1 rready = 1'b0;
  endtask

  task automatic poll_done(output logic [31:0] ctrl_v);
    int         n;
    logic [1:0] resp;
    n = 0;
    ctrl_v = 32'h0;
    while (!ctrl_v[1] && n < poll_limit) begin  // Bit 1 is done_sticky
      axil_read(reg_ctrl, 0, ctrl_v, resp);
      n++;
    end
    if (!ctrl_v[1]) report_problem("Timeout polling ctrl for done");
  endtask

  // One full multiply with its result handed to the compare process
  task automatic run_op(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                        input logic [7:0] acc, output logic [31:0] ctrl_v);
    logic [1:0]  resp;
    logic [31:0] got;
    axil_write(reg_instr, ins, 4'hF, 0, resp);
    axil_write(reg_rs1, a, 4'hF, 0, resp);
    axil_write(reg_rs2, b, 4'hF, 0, resp);
    axil_write(reg_acc, {24'h0, acc}, 4'hF, 0, resp);
    axil_write(reg_ctrl, 32'h1, 4'hF, 0, resp);
    poll_done(ctrl_v);
    axil_read(reg_result, 0, got, resp);
    exp_q.push_back(ref_mul(ins, a, b, acc));
    got_q.push_back(got);
  endtask

  task automatic drain_checks;
    int n;
    n = 0;
    while (got_q.size() != 0 && n < 10) begin
      @(posedge clk);
      #1 n++;
    end
    if (got_q.size() != 0) report_problem("Result compare queue did not drain");
  endtask

  task automatic end_test(input string name, input int err_start);
    drain_checks();
    tests++;
    if (errors == err_start) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err_start);
  endtask

  // Compare process takes one result per clock
  always @(posedge clk) begin
    if (got_q.size() != 0 && exp_q.size() != 0) begin
      cmp_exp = exp_q.pop_front();
      cmp_got = got_q.pop_front();
      checks++;
      assert (cmp_got == cmp_exp) else begin
        $display("Fail result exp=%h got=%h", cmp_exp, cmp_got);
        errors++;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] corner[5];
    logic [7:0]  levels[4];
    logic [31:0] bad[3];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ctrl_v;
    logic [31:0] rd;
    logic [1:0]  resp;
    int          err0;
    seed = 32'h4e00ad7b;
    errors = 0;
    checks = 0;
    tests = 0;
    rst = 1'b1;
    awaddr = 8'h0;
    awvalid = 1'b0;
    wdata = 32'h0;
    wstrb = 4'h0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = 8'h0;
    arvalid = 1'b0;
    rready = 1'b0;
    corner = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    levels = '{8'd1, 8'd8, 8'd16, 8'd40};   // 40 clamps to 31
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    #1;

    err0 = errors;  // Exact multiplies on corners then random pairs
    for (int f = 0; f < 4; f++) begin
      ins = make_instr(funct7_muldiv, 3'(f), opcode_op);
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) run_op(ins, corner[i], corner[j], 8'd0, ctrl_v);
      end
      for (int k = 0; k < 40; k++) begin
        a = $random(seed);
        b = $random(seed);
        run_op(ins, a, b, 8'd0, ctrl_v);
      end
    end
    end_test("exact multiplies", err0);

    err0 = errors;
    for (int l = 0; l < 4; l++) begin
      for (int f = 0; f < 4; f++) begin
        ins = make_instr(funct7_muldiv, 3'(f), opcode_op);
        for (int k = 0; k < 5; k++) begin
          a = $random(seed);
          b = $random(seed);
          run_op(ins, a, b, levels[l], ctrl_v);
        end
      end
    end
    end_test("approximation", err0);

    err0 = errors;
    bad[0] = make_instr(funct7_muldiv, funct3_mul, 7'b0110111);  // LUI opcode
    bad[1] = make_instr(7'b0100000, funct3_mul, opcode_op);      // SUB
    bad[2] = make_instr(funct7_muldiv, 3'd5, opcode_op);         // DIVU
    for (int i = 0; i < 3; i++) begin
      run_op(bad[i], 32'h1234_5678, 32'h9ABC_DEF0, 8'd0, ctrl_v);
      check_value("ctrl", 32'h6, ctrl_v);    // illegal and done without busy
    end
    run_op(make_instr(funct7_muldiv, funct3_mul, opcode_op), 32'h3, 32'h5, 8'd0, ctrl_v);
    check_value("ctrl", 32'h2, ctrl_v);      // Legal run clears illegal
    end_test("illegal instructions", err0);

    err0 = errors;
    a = $random(seed);
    b = $random(seed);
    ins = make_instr(funct7_muldiv, funct3_mulh, opcode_op);
    axil_write(reg_instr, ins, 4'hF, 0, resp);
    axil_write(reg_rs1, a, 4'hF, 0, resp);
    axil_write(reg_rs2, b, 4'hF, 0, resp);
    axil_write(reg_acc, 32'h0, 4'hF, 0, resp);
    axil_write(reg_ctrl, 32'h1, 4'hF, 0, resp);
    axil_write(reg_rs1, ~a, 4'hF, 0, resp);   // Would change the result if relaunched
    axil_write(reg_ctrl, 32'h1, 4'hF, 0, resp);
    check_value("bresp", 32'(resp_okay), {30'h0, resp});
    poll_done(ctrl_v);
    axil_read(reg_result, 0, rd, resp);
    exp_q.push_back(ref_mul(ins, a, b, 8'd0));
    got_q.push_back(rd);
    for (int i = 0; i < 3; i++) begin
      axil_read(reg_ctrl, 0, rd, resp);
      check_value("ctrl", 32'h2, rd);        // No second run started
    end
    axil_write(reg_instr, 32'h1234_5678, 4'hF, 0, resp);
    axil_write(reg_instr, 32'hAABB_CCDD, 4'b0101, 0, resp);
    axil_read(reg_instr, 0, rd, resp);
    check_value("instr", 32'h12BB_56DD, rd);
    axil_write(reg_rs1, 32'h0, 4'hF, 0, resp);
    axil_write(reg_rs1, 32'hFFFF_FFFF, 4'b1000, 0, resp);
    axil_read(reg_rs1, 0, rd, resp);
    check_value("rs1", 32'hFF00_0000, rd);
    axil_write(reg_rs2, 32'hCAFE_F00D, 4'hF, 0, resp);
    axil_write(reg_rs2, 32'h1122_3344, 4'b0110, 0, resp);
    axil_read(reg_rs2, 0, rd, resp);
    check_value("rs2", 32'hCA22_330D, rd);
    axil_write(reg_acc, 32'h0000_00A5, 4'hF, 0, resp);
    axil_write(reg_acc, 32'h0000_003C, 4'b1110, 0, resp);  // Byte 0 not strobed
    axil_read(reg_acc, 0, rd, resp);
    check_value("acc", 32'h0000_00A5, rd);
    end_test("start while busy and readback", err0);

    err0 = errors;
    axil_write(8'h18, 32'hDEAD_BEEF, 4'hF, 0, resp);
    check_value("bresp", 32'(resp_slverr), {30'h0, resp});
    axil_write(8'hFC, 32'hDEAD_BEEF, 4'hF, 0, resp);
    check_value("bresp", 32'(resp_slverr), {30'h0, resp});
    axil_read(8'h18, 0, rd, resp);
    check_value("rresp", 32'(resp_slverr), {30'h0, resp});
    check_value("rdata", 32'h0, rd);
    axil_read(8'h40, 0, rd, resp);
    check_value("rresp", 32'(resp_slverr), {30'h0, resp});
    check_value("rdata", 32'h0, rd);
    axil_write(reg_rs2, 32'h5A5A_1234, 4'hF, 6, resp);     // bready late
    check_value("bresp", 32'(resp_okay), {30'h0, resp});
    axil_read(reg_rs2, 7, rd, resp);                       // rready late
    check_value("rresp", 32'(resp_okay), {30'h0, resp});
    check_value("rdata", 32'h5A5A_1234, rd);
    end_test("bus errors and back-pressure", err0);

    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
